/* tb.f */
+incdir+bench
rtl/sched_cfg_pkg.sv
rtl/sched_cmd_pkg.sv
rtl/ready_queue.sv
rtl/cmd_decoder.sv
rtl/sleep_timer.sv
rtl/queue_arbiter.sv
rtl/sched_top.sv
bench/tb_sched.sv

/* Bender.yml */
package:
  name: task_sched

sources:
  - files:
      - rtl/sched_cfg_pkg.sv
      - rtl/sched_cmd_pkg.sv
      - rtl/ready_queue.sv
      - rtl/cmd_decoder.sv
      - rtl/sleep_timer.sv
      - rtl/queue_arbiter.sv
      - rtl/sched_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_sched.sv

/* bench/sched_model.svh */
`ifndef SCHED_MODEL_SVH
`define SCHED_MODEL_SVH

// Task states as the host sees them, stepped once per clock edge.
logic [sched_cfg_pkg::NUM_TASKS-1:0] m_queued;
logic [sched_cfg_pkg::NUM_TASKS-1:0] m_sleeping;   // From the sleep command until woken.
logic [sched_cfg_pkg::NUM_TASKS-1:0] m_active;     // Still counting ticks.
logic [sched_cfg_pkg::NUM_TASKS-1:0] m_pending;    // Count ran out, waiting for the bus.
logic [sched_cfg_pkg::PRI_W-1:0]     m_pri [sched_cfg_pkg::NUM_TASKS];
int                                  m_left [sched_cfg_pkg::NUM_TASKS];
int                                  quiet;        // Edges since the last queue transfer.

task automatic clear_model();
    m_queued   = '0;
    m_sleeping = '0;
    m_active   = '0;
    m_pending  = '0;
    quiet      = 100;
    for (int i = 0; i < sched_cfg_pkg::NUM_TASKS; i++) begin
        m_pri[i]  = '0;
        m_left[i] = 0;
    end
endtask

// One rising edge with the inputs sampled at that edge.
task automatic apply_edge(input logic v, input logic [sched_cmd_pkg::CMD_W-1:0] w,
                          input logic t);
    logic [1:0]                      op;
    sched_cmd_pkg::cmd_payload_t     p;
    logic [sched_cfg_pkg::ID_W-1:0]  id;
    logic                            accepted;
    int                              wake;
    op       = w[sched_cmd_pkg::CMD_W-1:sched_cmd_pkg::CMD_W-2];
    p        = w[sched_cmd_pkg::CMD_W-3:0];
    id       = p.task_form.id;   // Same bits in both forms.
    accepted = 1'b0;
    if (v) begin
        case (op)
            sched_cmd_pkg::OP_ADD:   accepted = !m_queued[id] && !m_sleeping[id];
            sched_cmd_pkg::OP_DEL:   accepted = m_queued[id];
            sched_cmd_pkg::OP_SLEEP: accepted = m_queued[id];
            default:                 accepted = 1'b0;
        endcase
    end
    // A wake-up only gets the bus when no host command is accepted.
    wake = -1;
    if (!accepted) begin
        for (int i = sched_cfg_pkg::NUM_TASKS - 1; i >= 0; i--) begin
            if (m_pending[i]) begin
                wake = i;
            end
        end
    end
    if (t) begin
        for (int i = 0; i < sched_cfg_pkg::NUM_TASKS; i++) begin
            if (m_active[i]) begin
                m_left[i]--;
                if (m_left[i] == 0) begin
                    m_active[i]  = 1'b0;
                    m_pending[i] = 1'b1;
                end
            end
        end
    end
    if (accepted && op == sched_cmd_pkg::OP_ADD) begin
        m_queued[id] = 1'b1;
        m_pri[id]    = p.task_form.pri;
    end else if (accepted) begin
        m_queued[id] = 1'b0;
        if (op == sched_cmd_pkg::OP_SLEEP) begin
            m_sleeping[id] = 1'b1;
            m_active[id]   = 1'b1;
            m_left[id]     = (p.sleep_form.ticks == 0) ? 1 : p.sleep_form.ticks;
        end
    end
    if (wake >= 0) begin
        m_pending[wake]  = 1'b0;
        m_sleeping[wake] = 1'b0;
        m_queued[wake]   = 1'b1;   // Returns with its stored priority.
    end
    quiet = (accepted || wake >= 0) ? 0 : quiet + 1;
endtask

task automatic check_id(input string what, input logic [sched_cfg_pkg::ID_W-1:0] got,
                        input logic [sched_cfg_pkg::ID_W-1:0] exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        stop_on_error();
    end
endtask

task automatic check_pri(input string what, input logic [sched_cfg_pkg::PRI_W-1:0] got,
                         input logic [sched_cfg_pkg::PRI_W-1:0] exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        stop_on_error();
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
        stop_on_error();
    end
endtask

task automatic check_size(input string what, input logic [sched_cfg_pkg::SIZE_W-1:0] got,
                          input logic [sched_cfg_pkg::SIZE_W-1:0] exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        stop_on_error();
    end
endtask

`endif

/* bench/tb_sched.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_sched;

    localparam int NUM_CMDS    = 400;
    localparam int CYCLE_LIMIT = NUM_CMDS * 8 + 100;

    logic                             clk;
    logic                             reset;
    logic                             cmd_valid;
    logic [sched_cmd_pkg::CMD_W-1:0]  cmd_word;
    logic                             tick;
    logic [sched_cfg_pkg::ID_W-1:0]   top_id;
    logic [sched_cfg_pkg::PRI_W-1:0]  top_pri;
    logic                             top_valid;
    logic [sched_cfg_pkg::SIZE_W-1:0] size;

    integer seed;
    int     cycles = 0;

    sched_top uut (
        .clk, .reset, .cmd_valid, .cmd_word, .tick,
        .top_id, .top_pri, .top_valid, .size
    );

    task automatic stop_on_error();
        $display("Verification failed");
        $fatal(1, "Stopping at the first error.");
    endtask

    `include "sched_model.svh"

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
            $display("Verification failed");
            $fatal(1, "Timeout.");
        end
    end

    // Model takes what the DUT samples at this edge, then new inputs go out.
    task automatic drive(input logic v, input logic [sched_cmd_pkg::CMD_W-1:0] w,
                         input logic t);
        @(posedge clk);
        apply_edge(cmd_valid, cmd_word, tick);
        cmd_valid <= v;
        cmd_word  <= w;
        tick      <= t;
    endtask

    function automatic logic [sched_cmd_pkg::CMD_W-1:0] random_command();
        logic [1:0]                  op;
        sched_cmd_pkg::cmd_payload_t p;
        op = $random(seed);
        if (op == sched_cmd_pkg::OP_SLEEP) begin
            p.sleep_form.id    = $random(seed);
            p.sleep_form.ticks = $random(seed) & 8'h0f;   // Short sleeps, zero included.
            p.sleep_form.spare = '0;
        end else begin
            p.task_form.id    = $random(seed);
            p.task_form.pri   = $random(seed);
            p.task_form.spare = '0;
        end
        return {op, p};
    endfunction

    task automatic compare_state();
        logic [sched_cfg_pkg::SIZE_W-1:0] n;
        logic [sched_cfg_pkg::PRI_W-1:0]  best;
        logic [sched_cfg_pkg::ID_W-1:0]   only_id;
        int                               ties;
        n       = '0;
        best    = '1;
        only_id = '0;
        ties    = 0;
        for (int i = 0; i < sched_cfg_pkg::NUM_TASKS; i++) begin
            if (m_queued[i]) begin
                n = n + 1'b1;
                if (m_pri[i] < best) best = m_pri[i];
            end
        end
        for (int i = 0; i < sched_cfg_pkg::NUM_TASKS; i++) begin
            if (m_queued[i] && m_pri[i] == best) begin
                ties++;
                only_id = i[sched_cfg_pkg::ID_W-1:0];
            end
        end
        check_size("size", size, n);
        check_flag("top_valid", top_valid, n != 0);
        if (n != 0) begin
            check_pri("top_pri", top_pri, best);
            check_flag("top_id at top priority", m_queued[top_id] && m_pri[top_id] == best, 1'b1);
            if (ties == 1) check_id("top_id", top_id, only_id);
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_word  = '0;
        tick      = 1'b0;
        seed      = 32'h559e1340;
        clear_model();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("top_valid", top_valid, 1'b0);
        check_size("size", size, '0);

        for (int n = 0; n < NUM_CMDS; n++) begin
            if (($random(seed) & 3) == 0) drive(1'b0, '0, 1'b1);
            else drive(1'b1, random_command(), 1'b0);
            repeat (4) drive(1'b0, '0, 1'b0);
            @(negedge clk);
            if (quiet >= 2) compare_state();   // Skipped while wake-ups still stream in.
        end

        // Tick until every sleeper is back in the queue.
        while (m_sleeping != 0) begin
            drive(1'b0, '0, 1'b1);
            repeat (4) drive(1'b0, '0, 1'b0);
        end
        repeat (4) drive(1'b0, '0, 1'b0);
        @(negedge clk);
        compare_state();

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/sched_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sched_top (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              cmd_valid,
    input  wire [sched_cmd_pkg::CMD_W-1:0]   cmd_word,
    input  wire                              tick,
    output logic [sched_cfg_pkg::ID_W-1:0]   top_id,
    output logic [sched_cfg_pkg::PRI_W-1:0]  top_pri,
    output logic                             top_valid,
    output logic [sched_cfg_pkg::SIZE_W-1:0] size
);

    logic                             dec_req_valid;
    logic                             dec_req_op;
    logic [sched_cfg_pkg::ID_W-1:0]   dec_req_id;
    logic [sched_cfg_pkg::PRI_W-1:0]  dec_req_pri;
    logic                             ld_valid;
    logic [sched_cfg_pkg::ID_W-1:0]   ld_id;
    logic [sched_cfg_pkg::TICK_W-1:0] ld_ticks;
    logic [sched_cfg_pkg::PRI_W-1:0]  ld_pri;
    logic                             tmr_req_valid;
    logic [sched_cfg_pkg::ID_W-1:0]   tmr_req_id;
    logic [sched_cfg_pkg::PRI_W-1:0]  tmr_req_pri;
    logic                             tmr_grant;
    logic                             q_valid;
    logic                             q_op;
    logic [sched_cfg_pkg::ID_W-1:0]   q_id;
    logic [sched_cfg_pkg::PRI_W-1:0]  q_pri;

    cmd_decoder u_decoder (
        .clk, .reset, .cmd_valid, .cmd_word, .tmr_grant,
        .wake_id (tmr_req_id),   // Granted wake-up marks the task queued again.
        .dec_req_valid, .dec_req_op, .dec_req_id, .dec_req_pri,
        .ld_valid, .ld_id, .ld_ticks, .ld_pri
    );

    sleep_timer u_timer (
        .clk, .reset, .tick,
        .ld_valid, .ld_id, .ld_ticks, .ld_pri,
        .tmr_grant, .tmr_req_valid, .tmr_req_id, .tmr_req_pri
    );

    queue_arbiter u_arbiter (
        .clk, .reset,
        .dec_req_valid, .dec_req_op, .dec_req_id, .dec_req_pri,
        .tmr_req_valid, .tmr_req_id, .tmr_req_pri,
        .tmr_grant, .q_valid, .q_op, .q_id, .q_pri
    );

    ready_queue u_queue (
        .clk, .reset, .q_valid, .q_op, .q_id, .q_pri,
        .top_id, .top_pri, .top_valid, .size
    );

endmodule

`default_nettype wire

/* rtl/queue_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module queue_arbiter (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               dec_req_valid,
    input  wire                               dec_req_op,
    input  wire [sched_cfg_pkg::ID_W-1:0]     dec_req_id,
    input  wire [sched_cfg_pkg::PRI_W-1:0]    dec_req_pri,
    input  wire                               tmr_req_valid,
    input  wire [sched_cfg_pkg::ID_W-1:0]     tmr_req_id,
    input  wire [sched_cfg_pkg::PRI_W-1:0]    tmr_req_pri,
    output logic                              tmr_grant,
    output logic                              q_valid,
    output logic                              q_op,
    output logic [sched_cfg_pkg::ID_W-1:0]    q_id,
    output logic [sched_cfg_pkg::PRI_W-1:0]   q_pri
);

    // Host commands cannot wait, so the decoder always wins.
    assign tmr_grant = tmr_req_valid && !dec_req_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            q_valid <= 1'b0;
        end else begin
            q_valid <= dec_req_valid || tmr_req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_req_valid) begin
            q_op  <= dec_req_op;
            q_id  <= dec_req_id;
            q_pri <= dec_req_pri;
        end else begin
            q_op  <= sched_cmd_pkg::QOP_ADD;   // A wake-up is always an add.
            q_id  <= tmr_req_id;
            q_pri <= tmr_req_pri;
        end
    end

    // A granted wake-up lands on the bus as an add of the same task.
    grant_to_bus: assert property (@(posedge clk) disable iff (reset)
        tmr_grant |-> !dec_req_valid ##1
            (q_valid && q_op == sched_cmd_pkg::QOP_ADD && q_id == $past(tmr_req_id)));

endmodule

`default_nettype wire

/* rtl/sleep_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module sleep_timer (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               tick,
    input  wire                               ld_valid,
    input  wire [sched_cfg_pkg::ID_W-1:0]     ld_id,
    input  wire [sched_cfg_pkg::TICK_W-1:0]   ld_ticks,
    input  wire [sched_cfg_pkg::PRI_W-1:0]    ld_pri,
    input  wire                               tmr_grant,
    output logic                              tmr_req_valid,
    output logic [sched_cfg_pkg::ID_W-1:0]    tmr_req_id,
    output logic [sched_cfg_pkg::PRI_W-1:0]   tmr_req_pri
);

    logic [sched_cfg_pkg::TICK_W-1:0]    cnt      [sched_cfg_pkg::NUM_TASKS];
    logic [sched_cfg_pkg::PRI_W-1:0]     slot_pri [sched_cfg_pkg::NUM_TASKS];
    logic [sched_cfg_pkg::NUM_TASKS-1:0] active;    // Counting down.
    logic [sched_cfg_pkg::NUM_TASKS-1:0] pending;   // Expired, waiting for the bus.

    // Lowest pending slot goes first.
    always_comb begin
        tmr_req_valid = |pending;
        tmr_req_id    = '0;
        for (int i = sched_cfg_pkg::NUM_TASKS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                tmr_req_id = i[sched_cfg_pkg::ID_W-1:0];
            end
        end
        tmr_req_pri = slot_pri[tmr_req_id];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active  <= '0;
            pending <= '0;
        end else begin
            for (int i = 0; i < sched_cfg_pkg::NUM_TASKS; i++) begin
                if (ld_valid && ld_id == i) begin
                    active[i]  <= 1'b1;
                    pending[i] <= 1'b0;
                end else if (tick && active[i] && cnt[i] == 1) begin
                    active[i]  <= 1'b0;   // Count reaches zero on this tick.
                    pending[i] <= 1'b1;
                end
            end
            if (tmr_grant) begin
                pending[tmr_req_id] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < sched_cfg_pkg::NUM_TASKS; i++) begin
            if (ld_valid && ld_id == i) begin
                cnt[i]      <= ld_ticks;
                slot_pri[i] <= ld_pri;
            end else if (tick && active[i]) begin
                cnt[i] <= cnt[i] - 1'b1;
            end
        end
    end

    // A presented slot has stopped counting.
    req_is_pending: assert property (@(posedge clk) disable iff (reset)
        tmr_req_valid |-> pending[tmr_req_id] && !active[tmr_req_id]);

    // No wake-up is dropped while the decoder holds the bus.
    req_held: assert property (@(posedge clk) disable iff (reset)
        tmr_req_valid && !tmr_grant |=> tmr_req_valid);

endmodule

`default_nettype wire

/* rtl/cmd_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module cmd_decoder (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                cmd_valid,
    input  wire [sched_cmd_pkg::CMD_W-1:0]     cmd_word,
    input  wire                                tmr_grant,
    input  wire [sched_cfg_pkg::ID_W-1:0]      wake_id,
    output logic                               dec_req_valid,
    output logic                               dec_req_op,
    output logic [sched_cfg_pkg::ID_W-1:0]     dec_req_id,
    output logic [sched_cfg_pkg::PRI_W-1:0]    dec_req_pri,
    output logic                               ld_valid,
    output logic [sched_cfg_pkg::ID_W-1:0]     ld_id,
    output logic [sched_cfg_pkg::TICK_W-1:0]   ld_ticks,
    output logic [sched_cfg_pkg::PRI_W-1:0]    ld_pri
);

    sched_cmd_pkg::cmd_payload_t payload;
    logic [1:0] op;

    // Idle tasks are in neither set.
    logic [sched_cfg_pkg::NUM_TASKS-1:0] queued;
    logic [sched_cfg_pkg::NUM_TASKS-1:0] sleeping;
    logic [sched_cfg_pkg::PRI_W-1:0]     pri_tab [sched_cfg_pkg::NUM_TASKS];

    logic add_ok;
    logic del_ok;
    logic sleep_ok;

    assign op      = cmd_word[sched_cmd_pkg::CMD_W-1:sched_cmd_pkg::PAYLOAD_W];
    assign payload = cmd_word[sched_cmd_pkg::PAYLOAD_W-1:0];

    always_comb begin
        add_ok   = 1'b0;
        del_ok   = 1'b0;
        sleep_ok = 1'b0;
        if (cmd_valid) begin
            case (op)
                sched_cmd_pkg::OP_ADD:   add_ok   = !queued[payload.task_form.id] &&
                                                    !sleeping[payload.task_form.id];
                sched_cmd_pkg::OP_DEL:   del_ok   = queued[payload.task_form.id];
                sched_cmd_pkg::OP_SLEEP: sleep_ok = queued[payload.sleep_form.id];
                sched_cmd_pkg::OP_NOP:   ;   // Dropped.
            endcase
        end
    end

    assign dec_req_valid = add_ok || del_ok || sleep_ok;
    assign dec_req_op    = add_ok ? sched_cmd_pkg::QOP_ADD : sched_cmd_pkg::QOP_DEL;
    assign dec_req_id    = payload.task_form.id;   // Same bits in the sleep form.
    assign dec_req_pri   = payload.task_form.pri;   // Ignored by the queue on a delete.

    // A sleeping task wakes with the priority it was queued at.
    assign ld_valid = sleep_ok;
    assign ld_id    = payload.sleep_form.id;
    assign ld_ticks = (payload.sleep_form.ticks == '0) ? sched_cfg_pkg::TICK_W'(1)
                                                       : payload.sleep_form.ticks;
    assign ld_pri   = pri_tab[payload.sleep_form.id];

    always_ff @(posedge clk) begin
        if (reset) begin
            queued   <= '0;
            sleeping <= '0;
        end else begin
            if (add_ok) begin
                queued[dec_req_id] <= 1'b1;
            end
            if (del_ok || sleep_ok) begin
                queued[dec_req_id] <= 1'b0;
            end
            if (sleep_ok) begin
                sleeping[ld_id] <= 1'b1;
            end
            // Grants only come in cycles without an accepted command.
            if (tmr_grant) begin
                sleeping[wake_id] <= 1'b0;
                queued[wake_id]   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (add_ok) begin
            pri_tab[dec_req_id] <= dec_req_pri;
        end
    end

    // A timer load always rides with the queue delete of the same task.
    load_with_del: assert property (@(posedge clk) disable iff (reset)
        ld_valid |-> dec_req_valid && dec_req_op == sched_cmd_pkg::QOP_DEL &&
                     dec_req_id == ld_id);

endmodule

`default_nettype wire

/* rtl/ready_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module ready_queue (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              q_valid,
    input  wire                              q_op,
    input  wire [sched_cfg_pkg::ID_W-1:0]    q_id,
    input  wire [sched_cfg_pkg::PRI_W-1:0]   q_pri,
    output logic [sched_cfg_pkg::ID_W-1:0]   top_id,
    output logic [sched_cfg_pkg::PRI_W-1:0]  top_pri,
    output logic                             top_valid,
    output logic [sched_cfg_pkg::SIZE_W-1:0] size
);

    logic [sched_cfg_pkg::ID_W-1:0]   reg_id  [sched_cfg_pkg::QUEUE_DEPTH];
    logic [sched_cfg_pkg::PRI_W-1:0]  reg_pri [sched_cfg_pkg::QUEUE_DEPTH];
    logic [sched_cfg_pkg::QUEUE_DEPTH-1:0] reg_valid;
    logic [sched_cfg_pkg::QUEUE_DEPTH-1:0] reg_move;   // Deferred shift-up per entry.
    logic [sched_cfg_pkg::SIZE_W-1:0]      reg_size;

    // Resolved view with pending moves applied.
    logic [sched_cfg_pkg::ID_W-1:0]   cur_id  [sched_cfg_pkg::QUEUE_DEPTH];
    logic [sched_cfg_pkg::PRI_W-1:0]  cur_pri [sched_cfg_pkg::QUEUE_DEPTH];
    logic [sched_cfg_pkg::QUEUE_DEPTH-1:0] cur_valid;

    logic [sched_cfg_pkg::ID_W-1:0]   nxt_id  [sched_cfg_pkg::QUEUE_DEPTH];
    logic [sched_cfg_pkg::PRI_W-1:0]  nxt_pri [sched_cfg_pkg::QUEUE_DEPTH];
    logic [sched_cfg_pkg::QUEUE_DEPTH-1:0] nxt_valid;
    logic [sched_cfg_pkg::QUEUE_DEPTH-1:0] nxt_move;
    logic [sched_cfg_pkg::SIZE_W-1:0]      nxt_size;

    logic [sched_cfg_pkg::QUEUE_DEPTH-1:0] keep;       // Entry stays ahead of the new task.
    logic [sched_cfg_pkg::QUEUE_DEPTH-1:0] del_mask;   // Set from the matching entry down.

    always_comb begin
        for (int i = 0; i < sched_cfg_pkg::QUEUE_DEPTH - 1; i++) begin
            cur_id[i]    = reg_move[i] ? reg_id[i+1]    : reg_id[i];
            cur_pri[i]   = reg_move[i] ? reg_pri[i+1]   : reg_pri[i];
            cur_valid[i] = reg_move[i] ? reg_valid[i+1] : reg_valid[i];
        end
        // The last entry has nothing below it.
        cur_id[sched_cfg_pkg::QUEUE_DEPTH-1]    = reg_id[sched_cfg_pkg::QUEUE_DEPTH-1];
        cur_pri[sched_cfg_pkg::QUEUE_DEPTH-1]   = reg_pri[sched_cfg_pkg::QUEUE_DEPTH-1];
        cur_valid[sched_cfg_pkg::QUEUE_DEPTH-1] = reg_valid[sched_cfg_pkg::QUEUE_DEPTH-1] &&
                                                  !reg_move[sched_cfg_pkg::QUEUE_DEPTH-1];
    end

    always_comb begin
        for (int i = 0; i < sched_cfg_pkg::QUEUE_DEPTH; i++) begin
            keep[i]     = cur_valid[i] && (cur_pri[i] <= q_pri);   // Equal priority stays first.
            del_mask[i] = (cur_valid[i] && cur_id[i] == q_id) || (i > 0 && del_mask[i-1]);
        end
    end

    always_comb begin
        nxt_id    = cur_id;
        nxt_pri   = cur_pri;
        nxt_valid = cur_valid;
        nxt_move  = '0;
        nxt_size  = reg_size;
        if (q_valid && q_op == sched_cmd_pkg::QOP_ADD) begin
            nxt_size = reg_size + 1'b1;
            // Shift-in: later entries slide down one place.
            for (int i = sched_cfg_pkg::QUEUE_DEPTH - 1; i > 0; i--) begin
                if (!keep[i]) begin
                    nxt_id[i]    = keep[i-1] ? q_id  : cur_id[i-1];
                    nxt_pri[i]   = keep[i-1] ? q_pri : cur_pri[i-1];
                    nxt_valid[i] = keep[i-1] ? 1'b1  : cur_valid[i-1];
                end
            end
            if (!keep[0]) begin
                nxt_id[0]    = q_id;
                nxt_pri[0]   = q_pri;
                nxt_valid[0] = 1'b1;
            end
        end else if (q_valid && q_op == sched_cmd_pkg::QOP_DEL &&
                     del_mask[sched_cfg_pkg::QUEUE_DEPTH-1]) begin
            nxt_size = reg_size - 1'b1;
            // The head pair closes up at once, deeper entries next cycle.
            for (int i = 0; i < 2; i++) begin
                if (del_mask[i]) begin
                    nxt_id[i]    = cur_id[i+1];
                    nxt_pri[i]   = cur_pri[i+1];
                    nxt_valid[i] = cur_valid[i+1];
                end
            end
            for (int i = 2; i < sched_cfg_pkg::QUEUE_DEPTH; i++) begin
                nxt_move[i] = del_mask[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_valid <= '0;
            reg_move  <= '0;
            reg_size  <= '0;
        end else begin
            reg_valid <= nxt_valid;
            reg_move  <= nxt_move;
            reg_size  <= nxt_size;
        end
    end

    always_ff @(posedge clk) begin
        reg_id  <= nxt_id;
        reg_pri <= nxt_pri;
    end

    assign top_id    = cur_id[0];
    assign top_pri   = cur_pri[0];
    assign top_valid = cur_valid[0];
    assign size      = reg_size;

    // Each task is queued at most once, so the count stays within the depth.
    size_bound: assert property (@(posedge clk) disable iff (reset)
        size <= sched_cfg_pkg::QUEUE_DEPTH);

endmodule

`default_nettype wire

/* rtl/sched_cmd_pkg.sv */
`default_nettype none

// Host command word and queue bus encodings.
package sched_cmd_pkg;

    localparam int CMD_W     = 16;
    localparam int PAYLOAD_W = CMD_W - 2;   // Bits below the opcode.

    // Opcodes in bits 15:14 of the command word.
    localparam logic [1:0] OP_ADD   = 2'd0;
    localparam logic [1:0] OP_DEL   = 2'd1;
    localparam logic [1:0] OP_SLEEP = 2'd2;
    localparam logic [1:0] OP_NOP   = 2'd3;

    // Op bit on the queue bus.
    localparam logic QOP_ADD = 1'b0;
    localparam logic QOP_DEL = 1'b1;

    // Add and delete carry a priority, sleep carries a tick count.
    typedef union packed {
        struct packed {
            logic [sched_cfg_pkg::ID_W-1:0]                                id;
            logic [sched_cfg_pkg::PRI_W-1:0]                               pri;
            logic [PAYLOAD_W-sched_cfg_pkg::ID_W-sched_cfg_pkg::PRI_W-1:0] spare;
        } task_form;
        struct packed {
            logic [sched_cfg_pkg::ID_W-1:0]                                 id;
            logic [sched_cfg_pkg::TICK_W-1:0]                               ticks;
            logic [PAYLOAD_W-sched_cfg_pkg::ID_W-sched_cfg_pkg::TICK_W-1:0] spare;
        } sleep_form;
    } cmd_payload_t;

endpackage

`default_nettype wire

/* rtl/sched_cfg_pkg.sv */
`default_nettype none

// Sizes shared by every block of the scheduler.
package sched_cfg_pkg;

    localparam int NUM_TASKS   = 16;         // Task ids 0 to 15.
    localparam int ID_W        = 4;          // Width of a task id.
    localparam int PRI_W       = 4;          // Lower value runs sooner.
    localparam int TICK_W      = 8;          // Width of a sleep count.

    // One entry per task, so an add can never find the queue full.
    localparam int QUEUE_DEPTH = NUM_TASKS;

    // Counts 0 to 16 inclusive.
    localparam int SIZE_W      = 5;

endpackage

`default_nettype wire
